// File: bench/sysctl_props.sv
// system controller properties
`default_nettype none

module sysctl_props #(
	parameter int RESET_BITS = 12,
	parameter int TICK_BITS = 16,
	parameter int BRAM_WORDS = sysctl_pkg::BRAM_WORDS_DEF,
	parameter int LED_BITS = 8
) (
	input logic sys_clk,
	input logic sys_rstn,
	input logic pll_locked_i,
	input logic ext_irq_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [sysctl_pkg::WB_ADR_BITS-1:0] wb_adr_i,
	input logic [sysctl_pkg::WB_SEL_BITS-1:0] wb_sel_i,
	input logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_i,
	input logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_o,
	input logic wb_ack_o,
	input logic ready_o,
	input logic [sysctl_pkg::IRQ_BITS-1:0] irq_o,
	input logic led_g_o,
	input logic led_b_o,
	input logic [LED_BITS-1:0] dbg_leds_o
);

	timeunit 1ns;
	timeprecision 1ps;

	import sysctl_pkg::*;

	localparam logic [RESET_BITS:0] LOCK_FULL = (RESET_BITS+1)'(2**RESET_BITS);
	localparam logic [TICK_BITS:0] GAP_FULL = (TICK_BITS+1)'(2**TICK_BITS);

	int unsigned fail_cnt = 0;	// read by the testbench
	logic [RESET_BITS:0] lock_cnt;
	logic [TICK_BITS:0] gap;
	logic [IRQ_BITS-1:0] irq_used;
	region_e region;
	logic req;

	// edges with reset released and lock held, saturating
	always_ff @(posedge sys_clk) begin
		if (!sys_rstn || !pll_locked_i)
			lock_cnt <= '0;
		else if (lock_cnt != LOCK_FULL)
			lock_cnt <= lock_cnt + 1'b1;
	end

	// cycles since ready or since the last timer pulse
	always_ff @(posedge sys_clk) begin
		if (!ready_o)
			gap <= '0;
		else if (irq_o[IRQ_TIMER_BIT])
			gap <= (TICK_BITS+1)'(1);
		else
			gap <= gap + 1'b1;
	end

	always_comb begin
		if (wb_adr_i[WB_ADR_BITS-1:2] < (WB_ADR_BITS-2)'(BRAM_WORDS))
			region = REGION_BRAM;
		else if (wb_adr_i[WB_ADR_BITS-1:REGION_SHIFT] == DEBUG_REGION)
			region = REGION_DEBUG;
		else
			region = REGION_NONE;
	end

	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign irq_used = (IRQ_BITS'(1) << IRQ_TIMER_BIT) | (IRQ_BITS'(1) << IRQ_EXT_BIT);

	ready_timing: assert property (@(posedge sys_clk) ready_o == (lock_cnt == LOCK_FULL))
		else begin fail_cnt++; $error("ready_o out of step with lock"); end

	ack_latency: assert property (@(posedge sys_clk) disable iff (!ready_o)
		(req && region != REGION_NONE) |=> wb_ack_o)
		else begin fail_cnt++; $error("no ack one cycle after strobe"); end

	ack_single: assert property (@(posedge sys_clk) wb_ack_o |=> !wb_ack_o)
		else begin fail_cnt++; $error("ack longer than one cycle"); end

	unmapped_quiet: assert property (@(posedge sys_clk)
		(wb_cyc_i && wb_stb_i && region == REGION_NONE) |-> (!wb_ack_o && wb_dat_o == '0))
		else begin fail_cnt++; $error("unmapped access answered"); end

	dbg_write: assert property (@(posedge sys_clk) disable iff (!ready_o)
		(req && wb_we_i && region == REGION_DEBUG && wb_sel_i[0])
		|=> dbg_leds_o == $past(wb_dat_i[LED_BITS-1:0]))
		else begin fail_cnt++; $error("debug register not written"); end

	dbg_masked: assert property (@(posedge sys_clk) disable iff (!ready_o)
		(req && wb_we_i && region == REGION_DEBUG && !wb_sel_i[0]) |=> $stable(dbg_leds_o))
		else begin fail_cnt++; $error("debug register changed without lane 0"); end

	dbg_readback: assert property (@(posedge sys_clk)
		(wb_ack_o && region == REGION_DEBUG)
		|-> (wb_dat_o == {{(WB_DAT_BITS-LED_BITS){1'b0}}, dbg_leds_o}))
		else begin fail_cnt++; $error("debug read back wrong"); end

	blue_led: assert property (@(posedge sys_clk) led_b_o == dbg_leds_o[0])
		else begin fail_cnt++; $error("led_b_o differs from register bit 0"); end

	timer_period: assert property (@(posedge sys_clk)
		ready_o |-> (irq_o[IRQ_TIMER_BIT] == (gap == GAP_FULL)))
		else begin fail_cnt++; $error("timer pulse off period"); end

	ext_follow: assert property (@(posedge sys_clk) (ready_o && $past(ready_o))
		|-> irq_o[IRQ_EXT_BIT] == $past(ext_irq_i))
		else begin fail_cnt++; $error("external irq not one cycle behind"); end

	irq_quiet: assert property (@(posedge sys_clk)
		((irq_o & ~irq_used) == '0) && (ready_o || irq_o == '0))
		else begin fail_cnt++; $error("unexpected irq bits"); end

	green_led: assert property (@(posedge sys_clk) led_g_o == !(|irq_o))
		else begin fail_cnt++; $error("led_g_o does not track irq_o"); end

endmodule

bind sysctl sysctl_props #(
	.RESET_BITS(RESET_BITS),
	.TICK_BITS(TICK_BITS),
	.BRAM_WORDS(BRAM_WORDS),
	.LED_BITS(LED_BITS)
) props0 (.*);

`default_nettype wire

// File: bench/sysctl_tb.sv
// system controller testbench
`default_nettype none

module sysctl_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_NS = 40;
	localparam int ACK_LIMIT = 8;
	localparam int BUDGET = 120 + 400 + 40 + 260 + 60 + 20;	// cycles per test, summed
	localparam int MARGIN = 200;

	logic sys_clk, sys_rstn, pll_locked_i, ext_irq_i;
	logic wb_cyc_i, wb_stb_i, wb_we_i;
	logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o;
	logic [3:0] wb_sel_i;
	logic wb_ack_o, ready_o, led_g_o, led_b_o;
	logic [31:0] irq_o;
	logic [7:0] dbg_leds_o;

	int read_errs = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	logic [31:0] model [int];	// bram contents by word index

	tb_clock #(.PERIOD_NS(CLK_NS)) clk0 (.clk_o(sys_clk));

	sysctl #(.RESET_BITS(4), .TICK_BITS(6)) dut0 (.*);

	function automatic int total_errs();
		return read_errs + int'(dut0.props0.fail_cnt);
	endfunction

	task automatic report_test(input string name, input int errs_before);
		int n;
		n = total_errs() - errs_before;
		if (n == 0)
			tests_ok++;
		else
			tests_bad++;
		$display("[%0t] test %s: %s, %0d errors", $time, name, (n == 0) ? "ok" : "bad", n);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			read_errs++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// one bus cycle, strobe held until ack or the limit runs out
	task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdat, output bit acked);
		int n;
		n = 0;
		acked = 0;
		@(negedge sys_clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_sel_i = sel;
		while (!acked && n < ACK_LIMIT) begin
			@(negedge sys_clk);
			n++;
			acked = wb_ack_o;
		end
		rdat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] rdat;
		bit acked;
		bus_cycle(adr, 1'b1, dat, sel, rdat, acked);
		if (!acked) begin
			read_errs++;
			$display("write to %h was never acknowledged", adr);
		end
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
		bit acked;
		bus_cycle(adr, 1'b0, 32'h0, 4'hF, rdat, acked);
		if (!acked) begin
			read_errs++;
			$display("read from %h was never acknowledged", adr);
		end
	endtask

	task automatic wait_ready(input logic level, input int limit);
		int n;
		n = 0;
		while (ready_o !== level && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (ready_o !== level) begin
			read_errs++;
			$display("ready_o did not reach %b in %0d cycles", level, limit);
		end
	endtask

	// watchdog
	initial begin
		#(CLK_NS * (BUDGET + MARGIN));
		$display("run timed out before all tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int e0;
		int widx;
		logic [31:0] dat, rdat;
		logic [3:0] sel;
		logic [7:0] leds;

		sys_rstn = 1'b0;
		pll_locked_i = 1'b0;
		ext_irq_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		void'($urandom(32'h633d));
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rstn = 1'b1;

		e0 = total_errs();
		pll_locked_i = 1'b1;
		wait_ready(1'b1, 30);
		repeat (3) @(negedge sys_clk);
		pll_locked_i = 1'b0;	// lose lock briefly
		wait_ready(1'b0, 4);
		pll_locked_i = 1'b1;
		wait_ready(1'b1, 30);
		report_test("reset sequencing", e0);

		e0 = total_errs();
		for (int i = 0; i < 24; i++) begin
			widx = $urandom_range(0, 2047);
			dat = $urandom;
			bus_write(widx << 2, dat, 4'hF);
			model[widx] = dat;
		end
		foreach (model[w]) begin
			dat = $urandom;
			sel = 4'($urandom_range(1, 15));
			bus_write(w << 2, dat, sel);
			for (int b = 0; b < 4; b++) begin
				if (sel[b])
					model[w][b*8 +: 8] = dat[b*8 +: 8];
			end
		end
		foreach (model[w]) begin
			bus_read(w << 2, rdat);
			check_value($sformatf("wb_dat_o[word %0d]", w), rdat, model[w]);
		end
		report_test("block ram", e0);

		e0 = total_errs();
		dat = $urandom;
		leds = dat[7:0];
		bus_write(32'hE000_0000, dat, 4'hF);
		check_value("dbg_leds_o", {24'h0, dbg_leds_o}, {24'h0, leds});
		check_value("led_b_o", {31'h0, led_b_o}, {31'h0, leds[0]});
		bus_write(32'hE000_0000, ~dat, 4'hE);	// lane 0 off, no change
		bus_read(32'hE000_0000, rdat);
		check_value("wb_dat_o[debug]", rdat, {24'h0, leds});
		report_test("debug register", e0);

		e0 = total_errs();
		for (int p = 0; p < 3; p++) begin
			@(posedge irq_o[3]);
		end
		report_test("timer interrupt", e0);

		e0 = total_errs();
		for (int i = 0; i < 12; i++) begin
			@(negedge sys_clk);
			ext_irq_i = 1'($urandom);
			repeat (i % 3) @(negedge sys_clk);
		end
		@(negedge sys_clk);
		ext_irq_i = 1'b0;
		report_test("external interrupt", e0);

		e0 = total_errs();
		begin
			bit acked;
			bus_cycle(32'h4000_0010, 1'b0, 32'h0, 4'hF, rdat, acked);
			if (acked) begin
				read_errs++;
				$display("unmapped read was acknowledged");
			end
			check_value("wb_dat_o[unmapped]", rdat, 32'h0);
		end
		report_test("unmapped access", e0);

		repeat (2) @(negedge sys_clk);
		$display("%0d tests ok, %0d tests bad, %0d errors", tests_ok, tests_bad, total_errs());
		if (total_errs() == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// testbench clock source
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;	// 50% duty
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/sysctl_pkg.sv
hdl/reset_seq.sv
hdl/irq_ctrl.sv
hdl/bus_decode.sv
hdl/bram_wb.sv
hdl/debug_wb.sv
hdl/sysctl.sv
bench/tb_clock.sv
bench/sysctl_props.sv
bench/sysctl_tb.sv

// File: hdl/bram_wb.sv
// boot block ram slave
`default_nettype none

module bram_wb #(
	parameter int BRAM_WORDS = sysctl_pkg::BRAM_WORDS_DEF
) (
	input  logic sys_clk,
	input  logic core_rst_i,
	input  logic [$clog2(BRAM_WORDS)-1:0] wb_adr_i,	// word index
	input  logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_i,
	input  logic [sysctl_pkg::WB_SEL_BITS-1:0] wb_sel_i,
	input  logic wb_we_i,
	input  logic wb_stb_i,
	input  logic wb_cyc_i,
	output logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_o,
	output logic wb_ack_o
);

	import sysctl_pkg::*;

	logic [WB_DAT_BITS-1:0] mem [BRAM_WORDS];
	logic [WB_DAT_BITS-1:0] rd_q;
	logic ack_q;
	logic access;

	// new request, not the tail of one just acked
	assign access = wb_cyc_i && wb_stb_i && !ack_q;

	// byte lane writes
	always_ff @(posedge sys_clk) begin
		if (access && wb_we_i) begin
			for (int i = 0; i < WB_SEL_BITS; i++) begin
				if (wb_sel_i[i])
					mem[wb_adr_i][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
			end
		end
	end

	// read port, lines up with the ack
	always_ff @(posedge sys_clk) begin
		rd_q <= mem[wb_adr_i];
	end

	always_ff @(posedge sys_clk) begin
		if (core_rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;	// one cycle pulse
		end
	end

	assign wb_dat_o = rd_q;
	assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

// File: hdl/bus_decode.sv
// wishbone address decoder
`default_nettype none

module bus_decode #(
	parameter int BRAM_WORDS = sysctl_pkg::BRAM_WORDS_DEF
) (
	// master side
	input  logic [sysctl_pkg::WB_ADR_BITS-1:0] wb_adr_i,
	input  logic wb_cyc_i,
	output logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_o,
	output logic wb_ack_o,

	// block ram slave
	input  logic [sysctl_pkg::WB_DAT_BITS-1:0] bram_dat_i,
	input  logic bram_ack_i,
	output logic bram_cyc_o,

	// debug register slave
	input  logic [sysctl_pkg::WB_DAT_BITS-1:0] dbg_dat_i,
	input  logic dbg_ack_i,
	output logic dbg_cyc_o
);

	import sysctl_pkg::*;

	// bram bound in words
	localparam logic [WB_ADR_BITS-3:0] BRAM_LIMIT = (WB_ADR_BITS-2)'(BRAM_WORDS);

	logic [WB_ADR_BITS-3:0] adr_word;
	logic [WB_ADR_BITS-REGION_SHIFT-1:0] adr_nibble;
	region_e region;

	assign adr_word = wb_adr_i[WB_ADR_BITS-1:2];	// byte address to word index
	assign adr_nibble = wb_adr_i[WB_ADR_BITS-1:REGION_SHIFT];

	// bram wins if both would match
	always_comb begin
		if (adr_word < BRAM_LIMIT) begin
			region = REGION_BRAM;
		end else if (adr_nibble == DEBUG_REGION) begin
			region = REGION_DEBUG;
		end else begin
			region = REGION_NONE;
		end
	end

	// only one slave ever sees cyc
	assign bram_cyc_o = wb_cyc_i && (region == REGION_BRAM);
	assign dbg_cyc_o = wb_cyc_i && (region == REGION_DEBUG);

	// return path
	always_comb begin
		case (region)
			REGION_BRAM: begin
				wb_dat_o = bram_dat_i;
				wb_ack_o = bram_ack_i;
			end
			REGION_DEBUG: begin
				wb_dat_o = dbg_dat_i;
				wb_ack_o = dbg_ack_i;
			end
			default: begin
				// unmapped reads give zero and hang until the master gives up
				wb_dat_o = '0;
				wb_ack_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/debug_wb.sv
// led debug register slave
`default_nettype none

module debug_wb #(
	parameter int LED_BITS = 8
) (
	input  logic sys_clk,
	input  logic core_rst_i,
	input  logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_i,
	input  logic [sysctl_pkg::WB_SEL_BITS-1:0] wb_sel_i,
	input  logic wb_we_i,
	input  logic wb_stb_i,
	input  logic wb_cyc_i,
	output logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic [LED_BITS-1:0] dbg_leds_o,
	output logic led_b_o
);

	import sysctl_pkg::*;

	logic [LED_BITS-1:0] led_q;
	logic ack_q;
	logic access;

	assign access = wb_cyc_i && wb_stb_i && !ack_q;

	always_ff @(posedge sys_clk) begin
		if (core_rst_i) begin
			led_q <= '0;
			ack_q <= 1'b0;
		end else begin
			// only lane 0 carries the register
			if (access && wb_we_i && wb_sel_i[0])
				led_q <= wb_dat_i[LED_BITS-1:0];
			ack_q <= access;
		end
	end

	// read back, upper bits zero
	assign wb_dat_o = {{(WB_DAT_BITS-LED_BITS){1'b0}}, led_q};
	assign wb_ack_o = ack_q;

	assign dbg_leds_o = led_q;
	assign led_b_o = led_q[0];	// blue board led

endmodule

`default_nettype wire

// File: hdl/irq_ctrl.sv
// tick timer and interrupt vector
`default_nettype none

module irq_ctrl #(
	parameter int TICK_BITS = 16
) (
	input  logic sys_clk,
	input  logic core_rst_i,
	input  logic ext_irq_i,
	output logic [sysctl_pkg::IRQ_BITS-1:0] irq_o,
	output logic led_g_o
);

	import sysctl_pkg::*;

	logic [TICK_BITS-1:0] tick_cnt;
	logic [TICK_BITS-1:0] tick_nxt;
	logic timer_q;
	logic ext_q;

	assign tick_nxt = tick_cnt + 1'b1;

	// free running, wraps every 2^TICK_BITS cycles
	always_ff @(posedge sys_clk) begin
		if (core_rst_i) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_nxt;
		end
	end

	// zero detect on the next count
	// the pulse is high for exactly the cycle the counter reads zero
	always_ff @(posedge sys_clk) begin
		if (core_rst_i) begin
			timer_q <= 1'b0;
			ext_q <= 1'b0;
		end else begin
			timer_q <= (tick_nxt == '0);
			ext_q <= ext_irq_i;	// one flop of delay
		end
	end

	always_comb begin
		irq_o = '0;
		irq_o[IRQ_TIMER_BIT] = timer_q;
		irq_o[IRQ_EXT_BIT] = ext_q;
	end

	// green led is lit (low) while anything is pending
	assign led_g_o = ~(|irq_o);

endmodule

`default_nettype wire

// File: hdl/reset_seq.sv
// lock qualified reset stretcher
`default_nettype none

module reset_seq #(
	parameter int RESET_BITS = 12
) (
	input  logic sys_clk,
	input  logic sys_rstn,
	input  logic pll_locked_i,
	output logic ready_o
);

	logic [RESET_BITS-1:0] stretch_cnt;
	logic cnt_full;
	logic ready_q;

	assign cnt_full = &stretch_cnt;

	// restart the count whenever lock is lost
	always_ff @(posedge sys_clk) begin
		if (!sys_rstn || !pll_locked_i) begin
			stretch_cnt <= '0;
			ready_q <= 1'b0;
		end else begin
			if (!cnt_full)
				stretch_cnt <= stretch_cnt + 1'b1;	// saturates at all ones
			ready_q <= cnt_full;
		end
	end

	// registered so the release lands on the 2^N-th edge
	assign ready_o = ready_q;

endmodule

`default_nettype wire

// File: hdl/sysctl.sv
// system controller top
`default_nettype none

module sysctl #(
	parameter int RESET_BITS = 12,
	parameter int TICK_BITS = 16,
	parameter int BRAM_WORDS = sysctl_pkg::BRAM_WORDS_DEF,
	parameter int LED_BITS = 8
) (
	input  logic sys_clk,
	input  logic sys_rstn,
	input  logic pll_locked_i,
	input  logic ext_irq_i,

	// wishbone master port, cpu side
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [sysctl_pkg::WB_ADR_BITS-1:0] wb_adr_i,
	input  logic [sysctl_pkg::WB_SEL_BITS-1:0] wb_sel_i,
	input  logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_i,
	output logic [sysctl_pkg::WB_DAT_BITS-1:0] wb_dat_o,
	output logic wb_ack_o,

	output logic ready_o,
	output logic [sysctl_pkg::IRQ_BITS-1:0] irq_o,
	output logic led_g_o,
	output logic led_b_o,
	output logic [LED_BITS-1:0] dbg_leds_o
);

	import sysctl_pkg::*;

	localparam int BRAM_AW = $clog2(BRAM_WORDS);

	logic core_rst;
	logic [BRAM_AW-1:0] bram_adr;
	logic bram_cyc, dbg_cyc;
	logic [WB_DAT_BITS-1:0] bram_dat, dbg_dat;
	logic bram_ack, dbg_ack;

	assign core_rst = ~ready_o;	// everything else waits for the sequencer
	assign bram_adr = wb_adr_i[BRAM_AW+1:2];

	reset_seq #(.RESET_BITS(RESET_BITS)) reset_seq0 (
		.sys_clk(sys_clk),
		.sys_rstn(sys_rstn),
		.pll_locked_i(pll_locked_i),
		.ready_o(ready_o)
	);

	irq_ctrl #(.TICK_BITS(TICK_BITS)) irq_ctrl0 (
		.sys_clk(sys_clk),
		.core_rst_i(core_rst),
		.ext_irq_i(ext_irq_i),
		.irq_o(irq_o),
		.led_g_o(led_g_o)
	);

	bus_decode #(.BRAM_WORDS(BRAM_WORDS)) bus_decode0 (
		.wb_adr_i(wb_adr_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.bram_dat_i(bram_dat),
		.bram_ack_i(bram_ack),
		.bram_cyc_o(bram_cyc),
		.dbg_dat_i(dbg_dat),
		.dbg_ack_i(dbg_ack),
		.dbg_cyc_o(dbg_cyc)
	);

	// boot code ram
	bram_wb #(.BRAM_WORDS(BRAM_WORDS)) bram0 (
		.sys_clk(sys_clk),
		.core_rst_i(core_rst),
		.wb_adr_i(bram_adr),
		.wb_dat_i(wb_dat_i),
		.wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i),
		.wb_stb_i(wb_stb_i),
		.wb_cyc_i(bram_cyc),
		.wb_dat_o(bram_dat),
		.wb_ack_o(bram_ack)
	);

	debug_wb #(.LED_BITS(LED_BITS)) debug0 (
		.sys_clk(sys_clk),
		.core_rst_i(core_rst),
		.wb_dat_i(wb_dat_i),
		.wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i),
		.wb_stb_i(wb_stb_i),
		.wb_cyc_i(dbg_cyc),
		.wb_dat_o(dbg_dat),
		.wb_ack_o(dbg_ack),
		.dbg_leds_o(dbg_leds_o),
		.led_b_o(led_b_o)
	);

endmodule

`default_nettype wire

// File: hdl/sysctl_pkg.sv
// system controller shared definitions
`default_nettype none

package sysctl_pkg;

	// wishbone bus widths
	localparam int WB_ADR_BITS = 32;
	localparam int WB_DAT_BITS = 32;
	localparam int WB_SEL_BITS = WB_DAT_BITS / 8;	// one select per byte lane

	// interrupt vector layout
	localparam int IRQ_BITS = 32;
	localparam int IRQ_TIMER_BIT = 3;	// periodic tick
	localparam int IRQ_EXT_BIT = 4;	// external source, old uart slot

	// address map
	// the top nibble picks a peripheral region
	localparam int REGION_SHIFT = 28;
	localparam logic [WB_ADR_BITS-REGION_SHIFT-1:0] DEBUG_REGION = 4'hE;

	// boot ram at address 0, 8 KiB by default
	localparam int BRAM_WORDS_DEF = 2048;

	// decoded slave region
	typedef enum logic [1:0] {
		REGION_BRAM,
		REGION_DEBUG,
		REGION_NONE	// unmapped, never acked
	} region_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the system controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module sysctl_tb -f filelist.f -o sysctl_sim

# keep going after assertion errors so the testbench prints its verdict
out=$(./obj_dir/sysctl_sim +verilator+error+limit+100000 || true)
echo "$out"

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1
